// ==== all.f ====
+incdir+hw
+incdir+bench
hw/cfu_pkg.sv
hw/tile_buffer.sv
hw/mac_pe.sv
hw/systolic_array.sv
hw/matmul_execute.sv
hw/cmd_decode.sv
hw/result_read.sv
hw/cfu_top.sv
bench/tb_cfu.sv

// ==== bench/tb_ref.svh ====
// reference operand store, xorshift generator, operand packing and reference product
`ifndef TB_REF_SVH
`define TB_REF_SVH

// A is row by k, B is k by column
byte a_mat [32][32];
byte b_mat [32][32];

logic [31:0] rng_state = 32'd36036;

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] next_random();
  logic [31:0] x;
  x = rng_state;
  x ^= x << 13;
  x ^= x >> 17;
  x ^= x << 5;
  rng_state = x;
  return x;
endfunction

// entry m*K+k of buffer A, row 4m+r in lane r
function automatic logic [31:0] pack_a_word(input int m_tile, input int k);
  return {a_mat[4*m_tile][k], a_mat[4*m_tile+1][k],
          a_mat[4*m_tile+2][k], a_mat[4*m_tile+3][k]};
endfunction

// entry n*K+k of buffer B, column 4n+c in lane c
function automatic logic [31:0] pack_b_word(input int n_tile, input int k);
  return {b_mat[k][4*n_tile], b_mat[k][4*n_tile+1],
          b_mat[k][4*n_tile+2], b_mat[k][4*n_tile+3]};
endfunction

// C[row][col], sum over k of (A + offset) times B
function automatic logic [31:0] ref_product(input int row, input int col,
                                            input int k_len, input int offset);
  int sum;
  sum = 0;
  for (int k = 0; k < k_len; k++) begin
    sum += (int'(a_mat[row][k]) + offset) * int'(b_mat[k][col]);
  end
  // int wraps the same way as the 32-bit accumulator
  return sum;
endfunction

`endif

// ==== bench/tb_cfu.sv ====
// clock, reset, command tasks, multiply scenarios, compare process and watchdog for cfu_top
`include "cfu_defines.svh"

module tb_cfu;

  localparam int clk_period = 4;
  // worst case dims with the appended row and column tiles
  localparam int max_k = 32;
  localparam int max_m = 20;
  localparam int max_n = 20;
  localparam int n_mults = 4;
  // one command with the longest response hold
  localparam int cmd_cycles = 16;
  // loads, reads, polls and strays plus the tile runs
  localparam int mult_cycles =
    ((max_m / 4 + max_n / 4) * max_k + max_m * max_n + 64) * cmd_cycles +
    (max_m / 4) * (max_n / 4) * (max_k + 16);

  logic        clk = 1'b0;
  logic        reset;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [9:0]  cmd_function_id;
  logic [31:0] cmd_inputs_0;
  logic [31:0] cmd_inputs_1;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_outputs_0;

  int          value_errors = 0;
  int          other_errors = 0;
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  logic [31:0] cmp_got;
  logic [31:0] cmp_exp;

  `include "tb_ref.svh"

  cfu_top UUT (
    .clk             (clk),
    .reset           (reset),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_outputs_0   (rsp_outputs_0)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // one command with the response held back for a random stretch
  task automatic issue_cmd(input logic [6:0] opcode, input logic [31:0] in0,
                           input logic [31:0] in1, output logic [31:0] result);
    logic [31:0] r;
    logic [31:0] first;
    int          hold;
    while (!cmd_ready) @(negedge clk);
    cmd_valid       = 1'b1;
    cmd_function_id = {opcode, 3'b000};
    cmd_inputs_0    = in0;
    cmd_inputs_1    = in1;
    @(negedge clk);
    cmd_valid = 1'b0;
    assert (rsp_valid === 1'b1 && cmd_ready === 1'b0) else begin
      other_errors++;
      $display("no response in the cycle after an accepted command at %0t", $time);
    end
    first = rsp_outputs_0;
    r     = next_random();
    // mostly short waits with a long stall now and then
    hold  = (r[7:5] == 3'd0) ? 4 + int'(r[2:0]) : int'(r[1:0]) % 3;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      assert (rsp_valid === 1'b1 && cmd_ready === 1'b0) else begin
        other_errors++;
        $display("response dropped or command accepted during a stall at %0t", $time);
      end
      check_value("rsp_outputs_0", rsp_outputs_0, first);
    end
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    assert (rsp_valid === 1'b0 && cmd_ready === 1'b1) else begin
      other_errors++;
      $display("handshake did not return to accept after the response at %0t", $time);
    end
    result = first;
  endtask

  task automatic poll_until_idle();
    logic [31:0] word;
    word = 32'd1;
    while (word != 32'd0) begin
      issue_cmd(`CFU_OP_POLL, 32'd0, 32'd0, word);
    end
  endtask

  // random int8 values for A rows in [first, last)
  task automatic fill_a_rows(input int first, input int last, input int k_len);
    for (int r = first; r < last; r++) begin
      for (int k = 0; k < k_len; k++) begin
        a_mat[r][k] = byte'(next_random());
      end
    end
  endtask

  // random int8 values for B columns in [first, last)
  task automatic fill_b_cols(input int first, input int last, input int k_len);
    for (int k = 0; k < k_len; k++) begin
      for (int c = first; c < last; c++) begin
        b_mat[k][c] = byte'(next_random());
      end
    end
  endtask

  // the unused input carries junk on A and B writes
  task automatic load_a(input int first_tile, input int last_tile, input int k_len);
    logic [31:0] word;
    for (int m = first_tile; m < last_tile; m++) begin
      for (int k = 0; k < k_len; k++) begin
        issue_cmd(`CFU_OP_WRITE_A, pack_a_word(m, k), next_random(), word);
      end
    end
  endtask

  task automatic load_b(input int first_tile, input int last_tile, input int k_len);
    logic [31:0] word;
    for (int n = first_tile; n < last_tile; n++) begin
      for (int k = 0; k < k_len; k++) begin
        issue_cmd(`CFU_OP_WRITE_B, next_random(), pack_b_word(n, k), word);
      end
    end
  endtask

  // offset and start followed by a poll that must still see busy
  task automatic start_multiply(input int k_len, input int m_len, input int n_len,
                                input int offset);
    logic [31:0] word;
    issue_cmd(`CFU_OP_OFFSET, 32'(offset), 32'd0, word);
    issue_cmd(`CFU_OP_START, {8'd0, 8'(k_len), 8'(m_len), 8'(n_len)}, 32'd0, word);
    issue_cmd(`CFU_OP_POLL, 32'd0, 32'd0, word);
    check_value("rsp_outputs_0", word, 32'd1);
  endtask

  // writes and a start that busy must swallow
  task automatic send_stray_commands();
    logic [31:0] word;
    issue_cmd(`CFU_OP_WRITE_A, next_random(), next_random(), word);
    issue_cmd(`CFU_OP_WRITE_B, next_random(), next_random(), word);
    issue_cmd(`CFU_OP_START, {8'd0, 8'd2, 8'd4, 8'd4}, 32'd0, word);
    issue_cmd(`CFU_OP_POLL, 32'd0, 32'd0, word);
    // still busy so all three really hit a running multiply
    check_value("rsp_outputs_0", word, 32'd1);
  endtask

  // entry e is row e%M of column tile e/M with lane 0 first
  task automatic read_result(input int k_len, input int m_len, input int n_len,
                             input int offset);
    logic [31:0] word;
    int          row;
    int          col;
    for (int e = 0; e < m_len * n_len / 4; e++) begin
      for (int j = 0; j < 4; j++) begin
        row = e % m_len;
        col = 4 * (e / m_len) + j;
        exp_q.push_back(ref_product(row, col, k_len, offset));
        issue_cmd(`CFU_OP_READ_C, 32'd0, 32'd0, word);
        got_q.push_back(word);
      end
    end
  endtask

  // read words against the reference one pair per clock
  always @(posedge clk) begin
    if (got_q.size() != 0) begin
      cmp_got = got_q.pop_front();
      cmp_exp = exp_q.pop_front();
      assert (cmp_got === cmp_exp) else begin
        value_errors++;
        $display("Error at %0t: rsp_outputs_0 is %h, expected %h", $time, cmp_got, cmp_exp);
      end
    end
  end

  initial begin
    #(clk_period * (n_mults * mult_cycles + 100));
    $display("watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] word;
    int          k_len;
    int          m_len;
    int          n_len;
    int          offset;
    reset           = 1'b1;
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    cmd_inputs_0    = '0;
    cmd_inputs_1    = '0;
    rsp_ready       = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // reset state
    assert (cmd_ready === 1'b1 && rsp_valid === 1'b0) else begin
      other_errors++;
      $display("handshake not in the accept state after reset");
    end
    issue_cmd(`CFU_OP_POLL, 32'd0, 32'd0, word);
    check_value("rsp_outputs_0", word, 32'd0);

    // first multiply long enough to absorb the stray commands
    k_len  = 16 + int'(next_random() % 17);
    m_len  = 8 << (next_random() % 2);
    n_len  = 8 << (next_random() % 2);
    offset = int'(next_random() % 17) - 8;
    issue_cmd(`CFU_OP_REWIND, 32'd0, 32'd0, word);
    fill_a_rows(0, m_len, k_len);
    fill_b_cols(0, n_len, k_len);
    load_a(0, m_len / 4, k_len);
    load_b(0, n_len / 4, k_len);
    start_multiply(k_len, m_len, n_len, offset);
    send_stray_commands();
    poll_until_idle();
    read_result(k_len, m_len, n_len, offset);

    // one more A row tile and B column tile without rewind after the dropped writes
    fill_a_rows(m_len, m_len + 4, k_len);
    fill_b_cols(n_len, n_len + 4, k_len);
    load_a(m_len / 4, m_len / 4 + 1, k_len);
    load_b(n_len / 4, n_len / 4 + 1, k_len);
    m_len += 4;
    n_len += 4;
    start_multiply(k_len, m_len, n_len, offset);
    poll_until_idle();
    read_result(k_len, m_len, n_len, offset);

    // fresh operands from index 0
    repeat (2) begin
      k_len  = 1 + int'(next_random() % 32);
      m_len  = 4 << (next_random() % 3);
      n_len  = 4 << (next_random() % 3);
      offset = int'(next_random() % 17) - 8;
      issue_cmd(`CFU_OP_REWIND, 32'd0, 32'd0, word);
      fill_a_rows(0, m_len, k_len);
      fill_b_cols(0, n_len, k_len);
      load_a(0, m_len / 4, k_len);
      load_b(0, n_len / 4, k_len);
      start_multiply(k_len, m_len, n_len, offset);
      poll_until_idle();
      read_result(k_len, m_len, n_len, offset);
    end

    while (got_q.size() != 0) @(posedge clk);
    @(negedge clk);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== hw/cfu_defines.svh ====
// buffer address width, array edge, opcode field position and opcode values
`ifndef CFU_DEFINES_SVH
`define CFU_DEFINES_SVH

// 256 entries per buffer
`define CFU_BUF_ADDR_BITS 8

// edge length of the systolic array
`define CFU_ARRAY_SIZE 4

// opcode sits in function_id[9:3]
`define CFU_OP_LSB 3
`define CFU_OP_WIDTH 7

`define CFU_OP_REWIND 7'd0
`define CFU_OP_WRITE_A 7'd1
`define CFU_OP_WRITE_B 7'd2
`define CFU_OP_START 7'd3
`define CFU_OP_POLL 7'd4
`define CFU_OP_READ_C 7'd5
`define CFU_OP_OFFSET 7'd6

`endif

// ==== hw/cfu_pkg.sv ====
// opcode enum, buffer index, operand word, result row and command side structs
`include "cfu_defines.svh"

package cfu_pkg;

  // decoded command, op_none for anything undefined
  typedef enum logic [2:0] {
    op_rewind  = 3'd0,
    op_write_a = 3'd1,
    op_write_b = 3'd2,
    op_start   = 3'd3,
    op_poll    = 3'd4,
    op_read_c  = 3'd5,
    op_offset  = 3'd6,
    op_none    = 3'd7
  } cfu_op_t;

  typedef logic [`CFU_BUF_ADDR_BITS-1:0] buf_index_t;

  // ascending range puts lane 0 in the top byte
  typedef logic [0:`CFU_ARRAY_SIZE-1][7:0] operand_word_t;

  // lane 0 in the top word, read out first
  typedef logic [0:`CFU_ARRAY_SIZE-1][31:0] result_row_t;

  typedef struct packed {
    logic [7:0]        k_len;
    logic [7:0]        m_len;
    logic [7:0]        n_len;
    logic signed [8:0] offset;
  } matmul_cfg_t;

  typedef struct packed {
    logic          en;
    buf_index_t    index;
    operand_word_t data;
  } buf_write_t;

  typedef struct packed {
    logic        en;
    buf_index_t  index;
    result_row_t row;
  } result_write_t;

endpackage

// ==== hw/cfu_top.sv ====
// top level, command decode, execute, result readout and the three tile buffers
module cfu_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  logic [9:0]  cmd_function_id,
  input  logic [31:0] cmd_inputs_0,
  input  logic [31:0] cmd_inputs_1,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output logic [31:0] rsp_outputs_0
);
  import cfu_pkg::*;

  logic          busy;
  logic          op_fire;
  cfu_op_t       op;
  buf_write_t    a_write;
  buf_write_t    b_write;
  logic          start;
  matmul_cfg_t   cfg;
  buf_index_t    a_rd_index;
  buf_index_t    b_rd_index;
  buf_index_t    c_rd_index;
  operand_word_t a_rd_data;
  operand_word_t b_rd_data;
  result_row_t   c_rd_data;
  result_write_t c_write;

  cmd_decode u_decode (
    .clk             (clk),
    .reset           (reset),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .busy            (busy),
    .op_fire         (op_fire),
    .op              (op),
    .a_write         (a_write),
    .b_write         (b_write),
    .start           (start),
    .cfg             (cfg)
  );

  matmul_execute u_execute (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .cfg        (cfg),
    .busy       (busy),
    .a_rd_index (a_rd_index),
    .b_rd_index (b_rd_index),
    .a_rd_data  (a_rd_data),
    .b_rd_data  (b_rd_data),
    .c_write    (c_write)
  );

  result_read u_result (
    .clk           (clk),
    .reset         (reset),
    .op_fire       (op_fire),
    .op            (op),
    .busy          (busy),
    .c_rd_index    (c_rd_index),
    .c_rd_data     (c_rd_data),
    .rsp_outputs_0 (rsp_outputs_0)
  );

  // A and B filled by the CPU, read by the sequencer
  tile_buffer #(.payload_t(operand_word_t)) buf_a (
    .clk      (clk),
    .wr_en    (a_write.en),
    .wr_index (a_write.index),
    .wr_data  (a_write.data),
    .rd_index (a_rd_index),
    .rd_data  (a_rd_data)
  );

  tile_buffer #(.payload_t(operand_word_t)) buf_b (
    .clk      (clk),
    .wr_en    (b_write.en),
    .wr_index (b_write.index),
    .wr_data  (b_write.data),
    .rd_index (b_rd_index),
    .rd_data  (b_rd_data)
  );

  // C filled by the sequencer, read back by the CPU
  tile_buffer #(.payload_t(result_row_t)) buf_c (
    .clk      (clk),
    .wr_en    (c_write.en),
    .wr_index (c_write.index),
    .wr_data  (c_write.row),
    .rd_index (c_rd_index),
    .rd_data  (c_rd_data)
  );

endmodule

// ==== hw/cmd_decode.sv ====
// command handshake, opcode decode, load pointers and matmul configuration
`include "cfu_defines.svh"

module cmd_decode (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  logic [9:0]           cmd_function_id,
  input  logic [31:0]          cmd_inputs_0,
  input  logic [31:0]          cmd_inputs_1,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  input  logic                 busy,
  output logic                 op_fire,
  output cfu_pkg::cfu_op_t     op,
  output cfu_pkg::buf_write_t  a_write,
  output cfu_pkg::buf_write_t  b_write,
  output logic                 start,
  output cfu_pkg::matmul_cfg_t cfg
);
  import cfu_pkg::*;

  typedef enum logic {st_accept, st_respond} hs_state_t;

  hs_state_t                state;
  logic [`CFU_OP_WIDTH-1:0] opcode;
  logic                     a_en;
  logic                     b_en;
  // last written entry or all ones after rewind
  buf_index_t               a_ptr;
  buf_index_t               b_ptr;
  operand_word_t            a_data;
  operand_word_t            b_data;

  assign cmd_ready = (state == st_accept);
  assign rsp_valid = (state == st_respond);
  assign op_fire   = cmd_valid && cmd_ready;
  assign opcode    = cmd_function_id[`CFU_OP_LSB +: `CFU_OP_WIDTH];

  always_comb begin
    case (opcode)
      `CFU_OP_REWIND:  op = op_rewind;
      `CFU_OP_WRITE_A: op = op_write_a;
      `CFU_OP_WRITE_B: op = op_write_b;
      `CFU_OP_START:   op = op_start;
      `CFU_OP_POLL:    op = op_poll;
      `CFU_OP_READ_C:  op = op_read_c;
      `CFU_OP_OFFSET:  op = op_offset;
      default:         op = op_none;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_accept;
      a_en  <= 1'b0;
      b_en  <= 1'b0;
      start <= 1'b0;
      a_ptr <= '1;
      b_ptr <= '1;
      cfg   <= '0;
    end else begin
      a_en  <= 1'b0;
      b_en  <= 1'b0;
      start <= 1'b0;
      case (state)
        st_accept:  if (op_fire) state <= st_respond;
        st_respond: if (rsp_ready) state <= st_accept;
        default:    state <= st_accept;
      endcase
      if (op_fire) begin
        case (op)
          op_rewind: begin
            a_ptr <= '1;
            b_ptr <= '1;
          end
          // buffers belong to the execute side while busy
          op_write_a: begin
            if (!busy) begin
              a_en  <= 1'b1;
              a_ptr <= a_ptr + 1'b1;
            end
          end
          op_write_b: begin
            if (!busy) begin
              b_en  <= 1'b1;
              b_ptr <= b_ptr + 1'b1;
            end
          end
          // dims packed as {8'b0, K, M, N}
          op_start: begin
            if (!busy) begin
              start     <= 1'b1;
              cfg.k_len <= cmd_inputs_0[23:16];
              cfg.m_len <= cmd_inputs_0[15:8];
              cfg.n_len <= cmd_inputs_0[7:0];
            end
          end
          op_offset: cfg.offset <= cmd_inputs_0[8:0];
          default: ;
        endcase
      end
    end
  end

  // A words come on inputs_0 and B words on inputs_1
  always_ff @(posedge clk) begin
    if (op_fire && op == op_write_a) begin
      a_data <= cmd_inputs_0;
    end
    if (op_fire && op == op_write_b) begin
      b_data <= cmd_inputs_1;
    end
  end

  assign a_write = '{en: a_en, index: a_ptr, data: a_data};
  assign b_write = '{en: b_en, index: b_ptr, data: b_data};

  // operand writes stay off the buffers while a multiply runs
  a_no_write_busy: assert property (@(posedge clk) disable iff (reset)
    (a_write.en || b_write.en) |-> !busy);

endmodule

// ==== hw/mac_pe.sv ====
// one output-stationary multiply-accumulate cell with right and down pass registers
module mac_pe (
  input  logic               clk,
  input  logic               reset,
  input  logic               clear,
  input  logic signed [8:0]  left_in,
  input  logic signed [7:0]  top_in,
  output logic signed [8:0]  right_out,
  output logic signed [7:0]  bottom_out,
  output logic signed [31:0] acc
);

  always_ff @(posedge clk) begin
    if (reset) begin
      right_out  <= '0;
      bottom_out <= '0;
      acc        <= '0;
    end else begin
      // operands keep flowing even while the sum is cleared
      right_out  <= left_in;
      bottom_out <= top_in;
      if (clear) begin
        acc <= '0;
      end else begin
        // signed product, wraps at 32 bits
        acc <= acc + left_in * top_in;
      end
    end
  end

endmodule

// ==== hw/matmul_execute.sv ====
// tile sequencer, operand skew lanes, offset add and result row writer
`include "cfu_defines.svh"

module matmul_execute (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  cfu_pkg::matmul_cfg_t   cfg,
  output logic                   busy,
  output cfu_pkg::buf_index_t    a_rd_index,
  output cfu_pkg::buf_index_t    b_rd_index,
  input  cfu_pkg::operand_word_t a_rd_data,
  input  cfu_pkg::operand_word_t b_rd_data,
  output cfu_pkg::result_write_t c_write
);
  import cfu_pkg::*;

  localparam int n_lanes   = `CFU_ARRAY_SIZE;
  localparam int lane_bits = $clog2(n_lanes);
  // read latency plus wavefront skew, counted from step 0
  localparam int drain_cycles = 2 * n_lanes - 1;

  typedef enum logic [1:0] {st_idle, st_feed, st_write, st_done} exec_state_t;

  exec_state_t                    state;
  matmul_cfg_t                    cfg_q;
  logic [7:0]                     step;
  logic [7:0]                     m_tile;
  logic [7:0]                     n_tile;
  buf_index_t                     a_base;
  buf_index_t                     b_base;
  buf_index_t                     c_ptr;
  logic                           fetch;
  logic                           rd_valid_q;
  logic                           last_row;
  logic                           clear;
  logic [0:n_lanes-1][8:0]        a_lane;
  operand_word_t                  b_lane;
  logic [0:n_lanes-1][8:0]        left_feed;
  operand_word_t                  top_feed;
  result_row_t [0:n_lanes-1]      rows;

  assign busy = (state != st_idle);

  // k-th entry of the current m and n tile
  assign a_rd_index = a_base + step;
  assign b_rd_index = b_base + step;
  assign fetch      = (state == st_feed) && (step < cfg_q.k_len);

  // tiles go out in order, so the C index n*M+4m+r is just a running count
  assign last_row = (c_ptr[lane_bits-1:0] == lane_bits'(n_lanes - 1));
  // idle, or the array has just drained into the row registers
  assign clear    = (state == st_idle) || ((state == st_write) && last_row);

  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      cfg_q <= cfg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      step       <= '0;
      m_tile     <= '0;
      n_tile     <= '0;
      a_base     <= '0;
      b_base     <= '0;
      c_ptr      <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= fetch;
      case (state)
        st_idle: begin
          if (start) begin
            step   <= '0;
            m_tile <= '0;
            n_tile <= '0;
            a_base <= '0;
            b_base <= '0;
            c_ptr  <= '0;
            state  <= st_feed;
          end
        end
        st_feed: begin
          step <= step + 8'd1;
          // last product has reached the row registers
          if (step == cfg_q.k_len + 8'(drain_cycles)) begin
            state <= st_write;
          end
        end
        st_write: begin
          c_ptr <= c_ptr + 1'b1;
          if (last_row) begin
            step  <= '0;
            state <= st_feed;
            // m walks first, then n
            if (m_tile + 8'd1 < (cfg_q.m_len >> lane_bits)) begin
              m_tile <= m_tile + 8'd1;
              a_base <= a_base + cfg_q.k_len;
            end else begin
              m_tile <= '0;
              a_base <= '0;
              if (n_tile + 8'd1 < (cfg_q.n_len >> lane_bits)) begin
                n_tile <= n_tile + 8'd1;
                b_base <= b_base + cfg_q.k_len;
              end else begin
                state <= st_done;
              end
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // zeros outside the k range, offset only on real A values
  always_comb begin
    for (int r = 0; r < n_lanes; r++) begin
      if (rd_valid_q) begin
        a_lane[r] = $signed(a_rd_data[r]) + cfg_q.offset;
        b_lane[r] = b_rd_data[r];
      end else begin
        a_lane[r] = '0;
        b_lane[r] = '0;
      end
    end
  end

  assign left_feed[0] = a_lane[0];
  assign top_feed[0]  = b_lane[0];

  // lane r delayed by r cycles
  for (genvar r = 1; r < n_lanes; r++) begin : g_skew
    logic [8:0] a_pipe [r];
    logic [7:0] b_pipe [r];

    always_ff @(posedge clk) begin
      a_pipe[0] <= a_lane[r];
      b_pipe[0] <= b_lane[r];
      for (int d = 1; d < r; d++) begin
        a_pipe[d] <= a_pipe[d-1];
        b_pipe[d] <= b_pipe[d-1];
      end
    end

    assign left_feed[r] = a_pipe[r-1];
    assign top_feed[r]  = b_pipe[r-1];
  end

  systolic_array u_array (
    .clk   (clk),
    .reset (reset),
    .clear (clear),
    .left  (left_feed),
    .top   (top_feed),
    .rows  (rows)
  );

  // one array row per write cycle
  always_comb begin
    c_write.en    = (state == st_write);
    c_write.index = c_ptr;
    c_write.row   = rows[c_ptr[lane_bits-1:0]];
  end

  a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

// ==== hw/result_read.sv ====
// response word select, C readout pointer and lane counter
`include "cfu_defines.svh"

module result_read (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 op_fire,
  input  cfu_pkg::cfu_op_t     op,
  input  logic                 busy,
  output cfu_pkg::buf_index_t  c_rd_index,
  input  cfu_pkg::result_row_t c_rd_data,
  output logic [31:0]          rsp_outputs_0
);
  import cfu_pkg::*;

  localparam int lane_bits = $clog2(`CFU_ARRAY_SIZE);

  buf_index_t           c_ptr;
  logic [lane_bits-1:0] lane;

  // row for c_ptr settles a cycle after the pointer moves
  assign c_rd_index = c_ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      c_ptr <= '0;
      lane  <= '0;
    end else if (op_fire) begin
      case (op)
        // idle poll rewinds the readout
        op_poll: begin
          if (!busy) begin
            c_ptr <= '0;
            lane  <= '0;
          end
        end
        op_read_c: begin
          lane <= lane + 1'b1;
          if (lane == lane_bits'(`CFU_ARRAY_SIZE - 1)) begin
            c_ptr <= c_ptr + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // captured on the accepting edge, held through the response
  always_ff @(posedge clk) begin
    if (op_fire) begin
      case (op)
        op_poll:   rsp_outputs_0 <= {31'd0, busy};
        op_read_c: rsp_outputs_0 <= c_rd_data[lane];
        default:   rsp_outputs_0 <= '0;
      endcase
    end
  end

endmodule

// ==== hw/systolic_array.sv ====
// grid of mac cells, edge feeding, cell chaining and registered result rows
`include "cfu_defines.svh"

module systolic_array (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   clear,
  input  logic [0:`CFU_ARRAY_SIZE-1][8:0]        left,
  input  cfu_pkg::operand_word_t                 top,
  output cfu_pkg::result_row_t [0:`CFU_ARRAY_SIZE-1] rows
);

  localparam int n = `CFU_ARRAY_SIZE;

  // horizontal and vertical links, indexed by the driving cell
  logic signed [8:0]  h_link   [n][n];
  logic signed [7:0]  v_link   [n][n];
  logic signed [31:0] acc_grid [n][n];

  for (genvar r = 0; r < n; r++) begin : g_row
    for (genvar c = 0; c < n; c++) begin : g_col
      logic signed [8:0] a_in;
      logic signed [7:0] b_in;

      // column 0 takes the skewed A lanes
      if (c == 0) begin : g_left_edge
        assign a_in = left[r];
      end else begin : g_left_link
        assign a_in = h_link[r][c-1];
      end

      // row 0 takes the skewed B lanes
      if (r == 0) begin : g_top_edge
        assign b_in = top[c];
      end else begin : g_top_link
        assign b_in = v_link[r-1][c];
      end

      mac_pe u_pe (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .left_in    (a_in),
        .top_in     (b_in),
        .right_out  (h_link[r][c]),
        .bottom_out (v_link[r][c]),
        .acc        (acc_grid[r][c])
      );
    end
  end

  // row r of the tile, lane c is output column c
  always_ff @(posedge clk) begin
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        rows[r][c] <= acc_grid[r][c];
      end
    end
  end

endmodule

// ==== hw/tile_buffer.sv ====
// simple dual-port synchronous buffer, one write port and one registered read port
`include "cfu_defines.svh"

module tile_buffer #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                clk,
  input  logic                wr_en,
  input  cfu_pkg::buf_index_t wr_index,
  input  payload_t            wr_data,
  input  cfu_pkg::buf_index_t rd_index,
  output payload_t            rd_data
);

  localparam int depth = 2 ** `CFU_BUF_ADDR_BITS;

  payload_t mem [depth];

  // read sees the old entry on a same-index write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
    rd_data <= mem[rd_index];
  end

  a_wr_index_known: assert property (@(posedge clk) wr_en |-> !$isunknown(wr_index));

endmodule
